// File: src/axil_fanout_pkg.sv
/*
 * Shared constants and types for the AXI-lite single-register fan-out.
 * The data width is fixed at 32 bits, with one register per slave.
 * A word index at or above NS returns the interconnect error code.
 */
package axil_fanout_pkg;

	////////////////////
	// Bus geometry
	////////////////////

	// Data bus width, one register per slave of this size
	parameter int DATA_W = 32;
	// One strobe per byte lane
	parameter int STRB_W = DATA_W / 8;
	// Byte offset bits dropped before the word index
	parameter int ADDR_LSBS = 2;

	////////////////////
	// Response codes
	////////////////////

	typedef logic [1:0] resp_t;

	parameter resp_t RESP_OKAY   = 2'b00;
	parameter resp_t RESP_SLVERR = 2'b10;
	// Returned by the fan-out itself for an unmapped word index
	parameter resp_t RESP_DECERR = 2'b11;

	// Write fields broadcast to every slave, qualified by its awvalid bit
	typedef struct packed {
		logic [2:0]        prot;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} wr_bcast_t;

	// One read return, as held in the R FIFO
	typedef struct packed {
		logic [DATA_W-1:0] data;
		resp_t             resp;
	} rd_ret_t;

endpackage

// File: src/resp_fifo.sv
/*
 * First-word-fall-through FIFO with a registered head.
 * o_data is valid whenever o_empty is low, one clock after the push.
 * The user must never push more than it can pop; no full flag leaves.
 * LGFLEN must be at least 1.
 */
module resp_fifo #(
	parameter int WIDTH  = 2,
	parameter int LGFLEN = 3
) (
	input  logic             S_AXI_ACLK,
	input  logic             S_AXI_ARESETN,
	input  logic             i_wr,
	input  logic [WIDTH-1:0] i_data,
	input  logic             i_rd,
	output logic [WIDTH-1:0] o_data,
	output logic             o_empty
);

	localparam int DEPTH = 1 << LGFLEN;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [LGFLEN:0]  wr_ptr, rd_ptr;
	logic             out_valid;
	logic             mem_empty, mem_full, load, bypass;

	assign mem_empty = (wr_ptr == rd_ptr);
	// Wrap bits differ with equal addresses when the buffer is full
	assign mem_full  = (wr_ptr[LGFLEN] != rd_ptr[LGFLEN])
		&& (wr_ptr[LGFLEN-1:0] == rd_ptr[LGFLEN-1:0]);
	// Head register takes a new word when empty or being popped
	assign load      = !out_valid || i_rd;
	// Empty buffer lets the pushed word go straight to the head
	assign bypass    = load && mem_empty && i_wr;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			if (i_wr && !bypass)
				wr_ptr <= wr_ptr + 1'b1;
			if (load)
			begin
				if (!mem_empty)
				begin
					rd_ptr    <= rd_ptr + 1'b1;
					out_valid <= 1'b1;
				end
				else
					out_valid <= i_wr;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr && !bypass)
			mem[wr_ptr[LGFLEN-1:0]] <= i_data;
		if (load)
			o_data <= mem_empty ? i_data : mem[rd_ptr[LGFLEN-1:0]];
	end

	assign o_empty = !out_valid;

	a_no_underflow: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) i_rd |-> out_valid);

	// Upstream outstanding counts keep the buffer below full
	a_no_overflow: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) i_wr |-> !mem_full);

endmodule

// File: src/axil_write_path.sv
/*
 * Write side of the fan-out: AW holding register, one-hot write pulse
 * qualified by WVALID, and BRESP capture two edges after the W handshake.
 * Accepted writes minus popped responses never exceed 2^LGFLEN.
 * Indices at or above NS answer RESP_DECERR without touching a slave.
 */
module axil_write_path #(
	parameter int NS     = 16,
	parameter int LGFLEN = 3,
	localparam int IDX_W = $clog2(NS),
	localparam int AW    = IDX_W + axil_fanout_pkg::ADDR_LSBS
) (
	input  logic                              S_AXI_ACLK,
	input  logic                              S_AXI_ARESETN,
	input  logic                              i_awvalid,
	output logic                              o_awready,
	input  logic [AW-1:0]                     i_awaddr,
	input  logic [2:0]                        i_awprot,
	input  logic                              i_wvalid,
	output logic                              o_wready,
	input  logic [axil_fanout_pkg::DATA_W-1:0] i_wdata,
	input  logic [axil_fanout_pkg::STRB_W-1:0] i_wstrb,
	input  logic                              i_bpop,
	output logic                              o_push,
	output axil_fanout_pkg::resp_t            o_resp,
	output logic [NS-1:0]                     o_m_awvalid,
	output axil_fanout_pkg::wr_bcast_t        o_m_wr,
	input  logic [NS*2-1:0]                   i_m_bresp
);

	localparam logic [LGFLEN:0] CNT_MAX = {1'b1, {LGFLEN{1'b0}}};

	logic                   aw_full, aw_acc, w_hs;
	logic [IDX_W-1:0]       aw_idx, idx1;
	logic [NS-1:0]          aw_sel;
	logic [2:0]             aw_prot;
	logic                   w_v1, w_v2;
	axil_fanout_pkg::resp_t resp2;
	logic [LGFLEN:0]        wr_cnt;

	////////////////////
	// AW holding register
	////////////////////

	// A new address may enter as the held one leaves with its data
	assign o_awready = (!aw_full || i_wvalid) && (wr_cnt != CNT_MAX);
	assign aw_acc    = i_awvalid && o_awready;
	assign o_wready  = aw_full;
	assign w_hs      = aw_full && i_wvalid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			aw_full <= 1'b0;
		else if (aw_acc)
			aw_full <= 1'b1;
		else if (w_hs)
			aw_full <= 1'b0;
	end

	// Index, one-hot select and prot ride with the held address
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_acc)
		begin
			aw_idx  <= i_awaddr[AW-1:axil_fanout_pkg::ADDR_LSBS];
			// Unmapped indices shift out and select nothing
			aw_sel  <= NS'(1) << i_awaddr[AW-1:axil_fanout_pkg::ADDR_LSBS];
			aw_prot <= i_awprot;
		end
	end

	////////////////////
	// Slave write pulse
	////////////////////

	// Pulse lasts exactly the W handshake cycle
	assign o_m_awvalid = w_hs ? aw_sel : '0;

	always_comb
	begin
		o_m_wr.prot = aw_prot;
		o_m_wr.data = i_wdata;
		o_m_wr.strb = i_wstrb;
	end

	////////////////////
	// BRESP pipeline
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			w_v1   <= 1'b0;
			w_v2   <= 1'b0;
			o_push <= 1'b0;
		end
		else
		begin
			w_v1   <= w_hs;
			w_v2   <= w_v1;
			o_push <= w_v2;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		// Stage 1 keeps the index once the holding register moves on
		idx1 <= aw_idx;
		// Slave BRESP is valid the clock after its pulse
		if ({1'b0, idx1} >= (IDX_W + 1)'(NS))
			resp2 <= axil_fanout_pkg::RESP_DECERR;
		else
			resp2 <= i_m_bresp[2*idx1 +: 2];
		o_resp <= resp2;
	end

	////////////////////
	// Outstanding count
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_cnt <= '0;
		else
		begin
			case ({aw_acc, i_bpop})
				2'b10: wr_cnt <= wr_cnt + 1'b1;
				2'b01: wr_cnt <= wr_cnt - 1'b1;
				default: wr_cnt <= wr_cnt;
			endcase
		end
	end

	// At most one slave sees a write per cycle
	a_awvalid_onehot: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) $onehot0(o_m_awvalid));

	// Pops never outrun pushes and stalls hold the count to the FIFO depth
	a_wr_cnt_bound: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) wr_cnt <= CNT_MAX);

	// A pending address has already been counted as outstanding
	a_wready_pending: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) o_wready |-> (wr_cnt != '0));

endmodule

// File: src/axil_read_path.sv
/*
 * Read side of the fan-out: one-cycle ARVALID pulse to the addressed
 * slave, then data and response picked the cycle the slave presents them.
 * Accepted reads minus popped returns never exceed 2^LGFLEN.
 * Indices at or above NS answer RESP_DECERR.
 */
module axil_read_path #(
	parameter int NS     = 16,
	parameter int LGFLEN = 3,
	localparam int IDX_W = $clog2(NS),
	localparam int AW    = IDX_W + axil_fanout_pkg::ADDR_LSBS
) (
	input  logic                              S_AXI_ACLK,
	input  logic                              S_AXI_ARESETN,
	input  logic                              i_arvalid,
	output logic                              o_arready,
	input  logic [AW-1:0]                     i_araddr,
	input  logic [2:0]                        i_arprot,
	input  logic                              i_rpop,
	output logic                              o_push,
	output axil_fanout_pkg::rd_ret_t          o_ret,
	output logic [NS-1:0]                     o_m_arvalid,
	output logic [2:0]                        o_m_arprot,
	input  logic [NS*axil_fanout_pkg::DATA_W-1:0] i_m_rdata,
	input  logic [NS*2-1:0]                   i_m_rresp
);

	localparam logic [LGFLEN:0] CNT_MAX = {1'b1, {LGFLEN{1'b0}}};

	logic             ar_hs;
	logic [IDX_W-1:0] ar_idx, idx_w, idx_v;
	logic             rd_wait, rd_valid;
	logic [LGFLEN:0]  rd_cnt;

	assign o_arready = (rd_cnt != CNT_MAX);
	assign ar_hs     = i_arvalid && o_arready;
	assign ar_idx    = i_araddr[AW-1:axil_fanout_pkg::ADDR_LSBS];

	////////////////////
	// Decode and issue
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_m_arvalid <= '0;
			rd_wait     <= 1'b0;
		end
		else
		begin
			// Out-of-range index shifts out, so no slave is pulsed
			o_m_arvalid <= ar_hs ? (NS'(1) << ar_idx) : '0;
			rd_wait     <= ar_hs;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_hs)
		begin
			o_m_arprot <= i_arprot;
			idx_w      <= ar_idx;
		end
	end

	////////////////////
	// Wait, valid, result
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rd_valid <= 1'b0;
			o_push   <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_wait;
			o_push   <= rd_valid;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		idx_v <= idx_w;
		// Slave data appears one clock after its pulse
		o_ret.data <= i_m_rdata[axil_fanout_pkg::DATA_W*idx_v +: axil_fanout_pkg::DATA_W];
		if ({1'b0, idx_v} >= (IDX_W + 1)'(NS))
			o_ret.resp <= axil_fanout_pkg::RESP_DECERR;
		else
			o_ret.resp <= i_m_rresp[2*idx_v +: 2];
	end

	////////////////////
	// Outstanding count
	////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_cnt <= '0;
		else
		begin
			case ({ar_hs, i_rpop})
				2'b10: rd_cnt <= rd_cnt + 1'b1;
				2'b01: rd_cnt <= rd_cnt - 1'b1;
				default: rd_cnt <= rd_cnt;
			endcase
		end
	end

	a_arvalid_onehot: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) $onehot0(o_m_arvalid));

	// Stall on ARREADY keeps every return inside the R FIFO
	a_rd_cnt_bound: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) rd_cnt <= CNT_MAX);

endmodule

// File: src/axil_fanout.sv
/*
 * AXI-lite slave port fanned out to NS single-register slaves.
 * Slaves must take any pulse and answer exactly one clock later.
 * NS must be at least 2 and LGFLEN at least 1.
 * Latency is four cycles from handshake to BVALID or RVALID.
 */
module axil_fanout #(
	parameter int NS     = 16,
	parameter int LGFLEN = 3,
	localparam int AW    = $clog2(NS) + axil_fanout_pkg::ADDR_LSBS
) (
	input  logic                              S_AXI_ACLK,
	input  logic                              S_AXI_ARESETN,
	// Write request
	input  logic                              i_awvalid,
	output logic                              o_awready,
	input  logic [AW-1:0]                     i_awaddr,
	input  logic [2:0]                        i_awprot,
	input  logic                              i_wvalid,
	output logic                              o_wready,
	input  logic [axil_fanout_pkg::DATA_W-1:0] i_wdata,
	input  logic [axil_fanout_pkg::STRB_W-1:0] i_wstrb,
	// Write response
	output logic                              o_bvalid,
	input  logic                              i_bready,
	output axil_fanout_pkg::resp_t            o_bresp,
	// Read request
	input  logic                              i_arvalid,
	output logic                              o_arready,
	input  logic [AW-1:0]                     i_araddr,
	input  logic [2:0]                        i_arprot,
	// Read response
	output logic                              o_rvalid,
	input  logic                              i_rready,
	output logic [axil_fanout_pkg::DATA_W-1:0] o_rdata,
	output axil_fanout_pkg::resp_t            o_rresp,
	// Slave side
	output logic [NS-1:0]                     o_m_awvalid,
	output axil_fanout_pkg::wr_bcast_t        o_m_wr,
	input  logic [NS*2-1:0]                   i_m_bresp,
	output logic [NS-1:0]                     o_m_arvalid,
	output logic [2:0]                        o_m_arprot,
	input  logic [NS*axil_fanout_pkg::DATA_W-1:0] i_m_rdata,
	input  logic [NS*2-1:0]                   i_m_rresp
);

	logic                     b_push, b_empty, b_pop;
	axil_fanout_pkg::resp_t   b_resp;
	logic                     r_push, r_empty, r_pop;
	axil_fanout_pkg::rd_ret_t r_ret, r_out;

	// Pops happen on the bus handshake
	assign b_pop = o_bvalid && i_bready;
	assign r_pop = o_rvalid && i_rready;

	axil_write_path #(
		.NS     (NS),
		.LGFLEN (LGFLEN)
	) u_write_path (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awvalid     (i_awvalid),
		.o_awready     (o_awready),
		.i_awaddr      (i_awaddr),
		.i_awprot      (i_awprot),
		.i_wvalid      (i_wvalid),
		.o_wready      (o_wready),
		.i_wdata       (i_wdata),
		.i_wstrb       (i_wstrb),
		.i_bpop        (b_pop),
		.o_push        (b_push),
		.o_resp        (b_resp),
		.o_m_awvalid   (o_m_awvalid),
		.o_m_wr        (o_m_wr),
		.i_m_bresp     (i_m_bresp)
	);

	axil_read_path #(
		.NS     (NS),
		.LGFLEN (LGFLEN)
	) u_read_path (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_arvalid     (i_arvalid),
		.o_arready     (o_arready),
		.i_araddr      (i_araddr),
		.i_arprot      (i_arprot),
		.i_rpop        (r_pop),
		.o_push        (r_push),
		.o_ret         (r_ret),
		.o_m_arvalid   (o_m_arvalid),
		.o_m_arprot    (o_m_arprot),
		.i_m_rdata     (i_m_rdata),
		.i_m_rresp     (i_m_rresp)
	);

	////////////////////
	// Return FIFOs
	////////////////////

	resp_fifo #(
		.WIDTH  ($bits(axil_fanout_pkg::resp_t)),
		.LGFLEN (LGFLEN)
	) u_bfifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_wr          (b_push),
		.i_data        (b_resp),
		.i_rd          (b_pop),
		.o_data        (o_bresp),
		.o_empty       (b_empty)
	);

	resp_fifo #(
		.WIDTH  ($bits(axil_fanout_pkg::rd_ret_t)),
		.LGFLEN (LGFLEN)
	) u_rfifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_wr          (r_push),
		.i_data        (r_ret),
		.i_rd          (r_pop),
		.o_data        (r_out),
		.o_empty       (r_empty)
	);

	// FIFO head drives the response channels directly
	assign o_bvalid = !b_empty;
	assign o_rvalid = !r_empty;
	assign o_rdata  = r_out.data;
	assign o_rresp  = r_out.resp;

endmodule

// File: dv/tb_slave_bank.sv
/*
 * Behavioural bank of NS single-register slaves for the fan-out testbench.
 * Each slave takes any pulse and answers one clock after it.
 * Read data is held until the slave's next read.
 * Odd slots answer SLVERR and even slots OKAY on both B and R.
 */
module tb_slave_bank #(
	parameter int NS = 12
) (
	input  logic                                  S_AXI_ACLK,
	input  logic                                  S_AXI_ARESETN,
	input  logic [NS-1:0]                         i_m_awvalid,
	input  axil_fanout_pkg::wr_bcast_t            i_m_wr,
	output logic [NS*2-1:0]                       o_m_bresp,
	input  logic [NS-1:0]                         i_m_arvalid,
	output logic [NS*axil_fanout_pkg::DATA_W-1:0] o_m_rdata,
	output logic [NS*2-1:0]                       o_m_rresp
);

	localparam int DW = axil_fanout_pkg::DATA_W;

	// One register per slave
	logic [DW-1:0] regs [NS];

	// Fixed answer of a slot, odd slots report a slave error
	function automatic axil_fanout_pkg::resp_t slot_resp(input int k);
		if (k % 2 == 1)
			return axil_fanout_pkg::RESP_SLVERR;
		else
			return axil_fanout_pkg::RESP_OKAY;
	endfunction

	always_ff @(posedge S_AXI_ACLK)
	begin
		for (int k = 0; k < NS; k++)
		begin
			if (!S_AXI_ARESETN)
			begin
				regs[k]               <= '0;
				o_m_bresp[2*k +: 2]   <= axil_fanout_pkg::RESP_OKAY;
				o_m_rdata[DW*k +: DW] <= '0;
				o_m_rresp[2*k +: 2]   <= axil_fanout_pkg::RESP_OKAY;
			end
			else
			begin
				// Write pulse doubles as WVALID, bytes merge under strobe
				if (i_m_awvalid[k])
				begin
					for (int b = 0; b < axil_fanout_pkg::STRB_W; b++)
						if (i_m_wr.strb[b])
							regs[k][8*b +: 8] <= i_m_wr.data[8*b +: 8];
					o_m_bresp[2*k +: 2] <= slot_resp(k);
				end
				// Read answer appears the clock after the pulse
				if (i_m_arvalid[k])
				begin
					o_m_rdata[DW*k +: DW] <= regs[k];
					o_m_rresp[2*k +: 2]   <= slot_resp(k);
				end
			end
		end
	end

endmodule

// File: dv/tb_axil_fanout.sv
/*
 * Testbench for the AXI-lite fan-out with NS = 12 and 8-deep returns.
 * Transactions go out one at a time except in the back-pressure tests.
 * Expected responses are queued at each handshake and checked in order.
 * Read data of an unmapped index is undefined and not compared.
 */
module tb_axil_fanout;

	localparam int NS      = 12;
	localparam int LGFLEN  = 3;
	localparam int IDX_W   = $clog2(NS);
	localparam int AW      = IDX_W + axil_fanout_pkg::ADDR_LSBS;
	localparam int DW      = axil_fanout_pkg::DATA_W;
	localparam int SW      = axil_fanout_pkg::STRB_W;
	localparam int PERIOD  = 100;
	localparam int DEPTH   = 1 << LGFLEN;
	// Transactions over all tests, sizes the watchdog
	localparam int N_TRANS = 304;

	logic                       S_AXI_ACLK, S_AXI_ARESETN;
	logic                       awvalid, awready, wvalid, wready, bvalid, bready;
	logic                       arvalid, arready, rvalid, rready;
	logic [AW-1:0]              awaddr, araddr;
	logic [2:0]                 awprot, arprot, m_arprot;
	logic [DW-1:0]              wdata, rdata;
	logic [SW-1:0]              wstrb;
	axil_fanout_pkg::resp_t     bresp, rresp;
	logic [NS-1:0]              m_awvalid, m_arvalid;
	axil_fanout_pkg::wr_bcast_t m_wr;
	logic [NS*2-1:0]            m_bresp, m_rresp;
	logic [NS*DW-1:0]           m_rdata;

	// Reference state and expected responses in request order
	logic [DW-1:0]          shadow [NS];
	axil_fanout_pkg::resp_t exp_bresp [$];
	axil_fanout_pkg::resp_t exp_rresp [$];
	logic [DW-1:0]          exp_rdata [$];
	logic [1:0]             ready_pat [256];
	int                     n_checks, n_errors, aw_accepted, ar_accepted, pat_i;
	logic                   toggling;
	integer                 seed;

	axil_fanout #(
		.NS     (NS),
		.LGFLEN (LGFLEN)
	) UUT (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awvalid     (awvalid),
		.o_awready     (awready),
		.i_awaddr      (awaddr),
		.i_awprot      (awprot),
		.i_wvalid      (wvalid),
		.o_wready      (wready),
		.i_wdata       (wdata),
		.i_wstrb       (wstrb),
		.o_bvalid      (bvalid),
		.i_bready      (bready),
		.o_bresp       (bresp),
		.i_arvalid     (arvalid),
		.o_arready     (arready),
		.i_araddr      (araddr),
		.i_arprot      (arprot),
		.o_rvalid      (rvalid),
		.i_rready      (rready),
		.o_rdata       (rdata),
		.o_rresp       (rresp),
		.o_m_awvalid   (m_awvalid),
		.o_m_wr        (m_wr),
		.i_m_bresp     (m_bresp),
		.o_m_arvalid   (m_arvalid),
		.o_m_arprot    (m_arprot),
		.i_m_rdata     (m_rdata),
		.i_m_rresp     (m_rresp)
	);

	tb_slave_bank #(
		.NS (NS)
	) u_slaves (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_m_awvalid   (m_awvalid),
		.i_m_wr        (m_wr),
		.o_m_bresp     (m_bresp),
		.i_m_arvalid   (m_arvalid),
		.o_m_rdata     (m_rdata),
		.o_m_rresp     (m_rresp)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(PERIOD/2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////
	// Reference model
	////////////////////

	// Unmapped index answers from the fan-out, else odd slots error
	function automatic axil_fanout_pkg::resp_t expected_resp(input int idx);
		if (idx >= NS)
			return axil_fanout_pkg::RESP_DECERR;
		else if (idx % 2 == 1)
			return axil_fanout_pkg::RESP_SLVERR;
		else
			return axil_fanout_pkg::RESP_OKAY;
	endfunction

	// Byte lanes with a strobe take the new data
	function automatic logic [DW-1:0] expected_data(input logic [DW-1:0] old_val,
		input logic [DW-1:0] new_val, input logic [SW-1:0] strb);
		logic [DW-1:0] merged;
		merged = old_val;
		for (int b = 0; b < SW; b++)
			if (strb[b])
				merged[8*b +: 8] = new_val[8*b +: 8];
		return merged;
	endfunction

	// Slave valid lines, only the addressed slot and none when unmapped
	function automatic logic [NS-1:0] expected_sel(input int idx);
		logic [NS-1:0] sel;
		sel = '0;
		for (int k = 0; k < NS; k++)
			if (k == idx)
				sel[k] = 1'b1;
		return sel;
	endfunction

	task automatic report_mismatch(input string name, input logic [DW-1:0] got,
		input logic [DW-1:0] exp);
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		n_errors++;
	endtask

	////////////////////
	// Bus stimulus
	////////////////////

	// AW and W go out together, each drops after its own handshake
	task automatic write_txn(input int idx, input logic [DW-1:0] data,
		input logic [SW-1:0] strb);
		logic aw_done, w_done;
		aw_done = 1'b0;
		w_done  = 1'b0;
		@(negedge S_AXI_ACLK);
		awvalid = 1'b1;
		awaddr  = {IDX_W'(idx), 2'($random(seed))};
		awprot  = 3'($random(seed));
		wvalid  = 1'b1;
		wdata   = data;
		wstrb   = strb;
		while (!(aw_done && w_done))
		begin
			// Handshakes are judged on pre-edge values
			@(posedge S_AXI_ACLK);
			if (awvalid && awready)
			begin
				aw_done = 1'b1;
				aw_accepted++;
			end
			if (wvalid && wready)
			begin
				w_done = 1'b1;
				exp_bresp.push_back(expected_resp(idx));
				if (idx < NS)
					shadow[idx] = expected_data(shadow[idx], data, strb);
				// Write pulse and prot reach the slaves in the W cycle
				n_checks++;
				if (m_awvalid !== expected_sel(idx))
					report_mismatch("o_m_awvalid", DW'(m_awvalid), DW'(expected_sel(idx)));
				n_checks++;
				if (m_wr.prot !== awprot)
					report_mismatch("o_m_wr.prot", DW'(m_wr.prot), DW'(awprot));
			end
			@(negedge S_AXI_ACLK);
			if (aw_done)
				awvalid = 1'b0;
			if (w_done)
				wvalid = 1'b0;
		end
	endtask

	task automatic read_txn(input int idx);
		logic done;
		done = 1'b0;
		@(negedge S_AXI_ACLK);
		arvalid = 1'b1;
		araddr  = {IDX_W'(idx), 2'($random(seed))};
		arprot  = 3'($random(seed));
		while (!done)
		begin
			@(posedge S_AXI_ACLK);
			if (arready)
			begin
				done = 1'b1;
				ar_accepted++;
				exp_rresp.push_back(expected_resp(idx));
				exp_rdata.push_back((idx < NS) ? shadow[idx] : '0);
			end
			@(negedge S_AXI_ACLK);
			if (done)
			begin
				arvalid = 1'b0;
				// Read pulse and prot show in the cycle after the handshake
				n_checks++;
				if (m_arvalid !== expected_sel(idx))
					report_mismatch("o_m_arvalid", DW'(m_arvalid), DW'(expected_sel(idx)));
				n_checks++;
				if (m_arprot !== arprot)
					report_mismatch("o_m_arprot", DW'(m_arprot), DW'(arprot));
			end
		end
	endtask

	task automatic wait_drained();
		while (exp_bresp.size() != 0 || exp_rresp.size() != 0)
			@(negedge S_AXI_ACLK);
		repeat (2) @(negedge S_AXI_ACLK);
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (n_errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, n_errors - errs_before);
	endtask

	// Ready pattern for the random mix, drawn up front
	always @(negedge S_AXI_ACLK)
	begin
		if (toggling)
		begin
			{bready, rready} = ready_pat[pat_i];
			pat_i = (pat_i + 1) % 256;
		end
	end

	////////////////////
	// Comparator
	////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		axil_fanout_pkg::resp_t er;
		logic [DW-1:0]          ed;
		if (S_AXI_ARESETN && bvalid && bready)
		begin
			if (exp_bresp.size() == 0)
			begin
				$display("Write response arrived with no write outstanding at %0t", $time);
				n_errors++;
			end
			else
			begin
				er = exp_bresp.pop_front();
				n_checks++;
				if (bresp !== er)
					report_mismatch("o_bresp", DW'(bresp), DW'(er));
			end
		end
		if (S_AXI_ARESETN && rvalid && rready)
		begin
			if (exp_rresp.size() == 0)
			begin
				$display("Read data arrived with no read outstanding at %0t", $time);
				n_errors++;
			end
			else
			begin
				er = exp_rresp.pop_front();
				ed = exp_rdata.pop_front();
				n_checks++;
				if (rresp !== er)
					report_mismatch("o_rresp", DW'(rresp), DW'(er));
				// Decode errors carry no data
				if (er != axil_fanout_pkg::RESP_DECERR && rdata !== ed)
					report_mismatch("o_rdata", rdata, ed);
			end
		end
	end

	////////////////////
	// Watchdog
	////////////////////

	initial
	begin
		repeat (N_TRANS * 20 + 2000) @(posedge S_AXI_ACLK);
		$display("Timeout: tests did not finish within %0d cycles", N_TRANS * 20 + 2000);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		int errs;
		seed          = 32'h15839908;
		S_AXI_ARESETN = 1'b0;
		awvalid       = 1'b0;
		awaddr        = '0;
		awprot        = '0;
		wvalid        = 1'b0;
		wdata         = '0;
		wstrb         = '0;
		bready        = 1'b1;
		arvalid       = 1'b0;
		araddr        = '0;
		arprot        = '0;
		rready        = 1'b1;
		toggling      = 1'b0;
		pat_i         = 0;
		n_checks      = 0;
		n_errors      = 0;
		aw_accepted   = 0;
		ar_accepted   = 0;
		for (int k = 0; k < NS; k++)
			shadow[k] = '0;
		for (int k = 0; k < 256; k++)
			ready_pat[k] = 2'($random(seed));
		repeat (10) @(negedge S_AXI_ACLK);

		// Reset state, ready high and nothing valid
		errs = n_errors;
		n_checks++;
		if ({awready, arready, wready, bvalid, rvalid} !== 5'b11000)
			report_mismatch("ready/valid after reset",
				DW'({awready, arready, wready, bvalid, rvalid}), DW'(5'b11000));
		n_checks++;
		if ({m_awvalid, m_arvalid} !== '0)
			report_mismatch("o_m_awvalid/o_m_arvalid", DW'({m_awvalid, m_arvalid}), '0);
		S_AXI_ARESETN = 1'b1;
		end_test("reset", errs);

		errs = n_errors;
		for (int k = 0; k < NS; k++)
			write_txn(k, $random(seed), {SW{1'b1}});
		for (int k = 0; k < NS; k++)
			read_txn(k);
		wait_drained();
		end_test("write then read back", errs);

		// Strobe patterns 1 to 12, all partial
		errs = n_errors;
		for (int k = 0; k < NS; k++)
			write_txn(k, $random(seed), SW'(k + 1));
		for (int k = 0; k < NS; k++)
			read_txn(k);
		wait_drained();
		end_test("byte strobes", errs);

		errs = n_errors;
		for (int k = NS; k < (1 << IDX_W); k++)
		begin
			write_txn(k, $random(seed), {SW{1'b1}});
			read_txn(k);
		end
		for (int k = 0; k < NS; k++)
			read_txn(k);
		wait_drained();
		end_test("unmapped indices", errs);

		// R FIFO fills, then ARREADY must stall
		errs = n_errors;
		rready      = 1'b0;
		ar_accepted = 0;
		fork
			for (int k = 0; k < NS; k++)
				read_txn(k);
			begin
				while (ar_accepted < DEPTH)
					@(negedge S_AXI_ACLK);
				repeat (10) @(negedge S_AXI_ACLK);
				n_checks++;
				if (ar_accepted != DEPTH)
					report_mismatch("reads accepted", DW'(ar_accepted), DW'(DEPTH));
				n_checks++;
				if (arready !== 1'b0)
					report_mismatch("o_arready", DW'(arready), '0);
				rready = 1'b1;
			end
		join
		wait_drained();
		end_test("read back-pressure", errs);

		// B FIFO fills, then AWREADY must stall
		errs = n_errors;
		bready      = 1'b0;
		aw_accepted = 0;
		fork
			for (int k = 0; k < NS; k++)
				write_txn(k, $random(seed), {SW{1'b1}});
			begin
				while (aw_accepted < DEPTH)
					@(negedge S_AXI_ACLK);
				repeat (10) @(negedge S_AXI_ACLK);
				n_checks++;
				if (aw_accepted != DEPTH)
					report_mismatch("writes accepted", DW'(aw_accepted), DW'(DEPTH));
				n_checks++;
				if (awready !== 1'b0)
					report_mismatch("o_awready", DW'(awready), '0);
				bready = 1'b1;
			end
		join
		for (int k = 0; k < NS; k++)
			read_txn(k);
		wait_drained();
		end_test("write back-pressure", errs);

		// Random slots including unmapped ones, ready toggling each cycle
		errs     = n_errors;
		toggling = 1'b1;
		for (int n = 0; n < 200; n++)
		begin
			if ($random(seed) & 1)
				write_txn($unsigned($random(seed)) % (1 << IDX_W), $random(seed),
					SW'($random(seed)));
			else
				read_txn($unsigned($random(seed)) % (1 << IDX_W));
		end
		toggling = 1'b0;
		@(negedge S_AXI_ACLK);
		bready = 1'b1;
		rready = 1'b1;
		wait_drained();
		end_test("random mix", errs);

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: flist.f
src/axil_fanout_pkg.sv
src/resp_fifo.sv
src/axil_write_path.sv
src/axil_read_path.sv
src/axil_fanout.sv
dv/tb_slave_bank.sv
dv/tb_axil_fanout.sv

// File: Makefile
# Verilator build and run of the AXI-lite fan-out testbench
TOP = tb_axil_fanout

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f flist.f

# A missing pass line also counts as failure, e.g. after an assertion stop
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
